// ==== list.f ====
rtl/cpu_pkg.sv
rtl/cpu_fetch.sv
rtl/cpu_decode.sv
rtl/cpu_registers.sv
rtl/cpu_execute.sv
rtl/cpu_memory.sv
rtl/cpu.sv
testbench/tb_clock.sv
testbench/tb_cpu.sv

// ==== rtl/cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu import cpu_pkg::*; #(
	parameter word_t RESET_VECTOR = 32'h00000000,
	parameter word_t STACK_POINTER = 32'h00001000
)(
	input wire i_clock,
	input wire i_rst_n,

	// Instruction bus
	output wire o_ibus_request,
	input wire i_ibus_ready,
	output wire word_t o_ibus_address,
	input wire word_t i_ibus_rdata,

	// Data bus
	output wire o_dbus_request,
	output wire o_dbus_rw,
	input wire i_dbus_ready,
	output wire word_t o_dbus_address,
	input wire word_t i_dbus_rdata,
	output wire word_t o_dbus_wdata,
	output wire [3:0] o_dbus_wmask,

	output wire o_fault
);

	fetch_data_t fetch_data;
	decode_data_t decode_data;
	execute_data_t execute_data;
	logic decode_fault;
	word_t rs1;
	word_t rs2;
	logic execute_busy;
	logic execute_jump;
	word_t execute_jump_pc;
	logic memory_busy;
	logic wb_wr;
	reg_index_t wb_rd;
	word_t wb_data;
	logic stall;

	assign stall = execute_busy | memory_busy;

	// ========================================
	// Front end

	cpu_fetch #(
		.RESET_VECTOR(RESET_VECTOR)
	) fetch (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_jump(execute_jump),
		.i_jump_pc(execute_jump_pc),
		.i_busy(stall),
		.o_bus_request(o_ibus_request),
		.i_bus_ready(i_ibus_ready),
		.o_bus_address(o_ibus_address),
		.i_bus_rdata(i_ibus_rdata),
		.o_data(fetch_data)
	);

	cpu_decode decode (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_busy(stall),
		.i_flush(execute_jump),
		.i_data(fetch_data),
		.o_data(decode_data),
		.o_fault(decode_fault)
	);

	// Operands are read for the instruction entering execute
	cpu_registers #(
		.STACK_POINTER(STACK_POINTER)
	) registers (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_rs1(decode_data.rs1),
		.i_rs2(decode_data.rs2),
		.i_wr(wb_wr),
		.i_rd(wb_rd),
		.i_wdata(wb_data),
		.o_rs1(rs1),
		.o_rs2(rs2)
	);

	// ========================================
	// Back end

	cpu_execute execute (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_memory_busy(memory_busy),
		.i_data(decode_data),
		.i_rs1(rs1),
		.i_rs2(rs2),
		.i_wb_wr(wb_wr),
		.i_wb_rd(wb_rd),
		.i_wb_data(wb_data),
		.o_busy(execute_busy),
		.o_jump(execute_jump),
		.o_jump_pc(execute_jump_pc),
		.o_data(execute_data)
	);

	cpu_memory memory (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_data(execute_data),
		.o_bus_request(o_dbus_request),
		.o_bus_rw(o_dbus_rw),
		.i_bus_ready(i_dbus_ready),
		.o_bus_address(o_dbus_address),
		.i_bus_rdata(i_dbus_rdata),
		.o_bus_wdata(o_dbus_wdata),
		.o_bus_wmask(o_dbus_wmask),
		.o_busy(memory_busy),
		.o_wb_wr(wb_wr),
		.o_wb_rd(wb_rd),
		.o_wb_data(wb_data)
	);

	assign o_fault = decode_fault;

endmodule

`default_nettype wire

// ==== rtl/cpu_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_decode import cpu_pkg::*; (
	input wire i_clock,
	input wire i_rst_n,
	input wire i_busy,
	input wire i_flush,
	input wire fetch_data_t i_data,
	output decode_data_t o_data,
	output logic o_fault
);

	word_t instruction;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t imm_i;
	word_t imm_s;
	word_t imm_b;
	word_t imm_j;
	decode_data_t decoded;
	decode_data_t payload;
	logic legal;
	logic valid_q;

	assign instruction = i_data.instruction;
	assign opcode = instruction[6:0];
	assign funct3 = instruction[14:12];
	assign funct7 = instruction[31:25];

	// ========================================
	// Immediate formats
	assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
	assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
	assign imm_b = {{19{instruction[31]}}, instruction[31], instruction[7],
		instruction[30:25], instruction[11:8], 1'b0};
	assign imm_j = {{11{instruction[31]}}, instruction[31], instruction[19:12],
		instruction[20], instruction[30:21], 1'b0};

	always_comb begin
		decoded = '0;
		decoded.valid = i_data.valid;
		decoded.pc = i_data.pc;
		decoded.rd = instruction[11:7];
		legal = 1'b1;
		case (opcode)
			OP_LUI: begin
				decoded.immediate = {instruction[31:12], 12'b0};
				decoded.alu_op = ALU_PASS_B;
				decoded.use_immediate = 1'b1;
				decoded.writes_rd = 1'b1;
			end
			OP_IMM: begin
				decoded.rs1 = instruction[19:15];
				decoded.immediate = imm_i;
				decoded.use_immediate = 1'b1;
				decoded.writes_rd = 1'b1;
				case (funct3)
					3'b000: decoded.alu_op = ALU_ADD;
					3'b111: decoded.alu_op = ALU_AND;
					3'b110: decoded.alu_op = ALU_OR;
					3'b100: decoded.alu_op = ALU_XOR;
					default: legal = 1'b0;
				endcase
			end
			OP_REG: begin
				decoded.rs1 = instruction[19:15];
				decoded.rs2 = instruction[24:20];
				decoded.writes_rd = 1'b1;
				case ({funct7, funct3})
					{7'b0000000, 3'b000}: decoded.alu_op = ALU_ADD;
					{7'b0100000, 3'b000}: decoded.alu_op = ALU_SUB;
					{7'b0000000, 3'b111}: decoded.alu_op = ALU_AND;
					{7'b0000000, 3'b110}: decoded.alu_op = ALU_OR;
					{7'b0000000, 3'b100}: decoded.alu_op = ALU_XOR;
					default: legal = 1'b0;
				endcase
			end
			OP_LOAD: begin
				decoded.rs1 = instruction[19:15];
				decoded.immediate = imm_i;
				decoded.alu_op = ALU_ADD;
				decoded.use_immediate = 1'b1;
				decoded.is_load = 1'b1;
				decoded.writes_rd = 1'b1;
				legal = (funct3 == 3'b010);
			end
			OP_STORE: begin
				decoded.rs1 = instruction[19:15];
				decoded.rs2 = instruction[24:20];
				decoded.immediate = imm_s;
				decoded.alu_op = ALU_ADD;
				decoded.use_immediate = 1'b1;
				decoded.is_store = 1'b1;
				legal = (funct3 == 3'b010);
			end
			OP_BRANCH: begin
				decoded.rs1 = instruction[19:15];
				decoded.rs2 = instruction[24:20];
				decoded.immediate = imm_b;
				decoded.is_branch = 1'b1;
				decoded.branch_not_equal = funct3[0];
				legal = (funct3[2:1] == 2'b00);
			end
			OP_JAL: begin
				decoded.immediate = imm_j;
				decoded.is_jump = 1'b1;
				decoded.writes_rd = 1'b1;
			end
			default: begin
				legal = 1'b0;
			end
		endcase
		// x0 as destination never writes and never forwards
		if (decoded.rd == '0) begin
			decoded.writes_rd = 1'b0;
		end
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			valid_q <= 1'b0;
			o_fault <= 1'b0;
		end else if (i_flush) begin
			valid_q <= 1'b0;
		end else if (!i_busy) begin
			valid_q <= i_data.valid && legal;
			if (i_data.valid && !legal) begin
				o_fault <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (!i_busy) begin
			payload <= decoded;
		end
	end

	always_comb begin
		o_data = payload;
		o_data.valid = valid_q;
	end

endmodule

`default_nettype wire

// ==== rtl/cpu_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_execute import cpu_pkg::*; (
	input wire i_clock,
	input wire i_rst_n,
	input wire i_memory_busy,
	input wire decode_data_t i_data,
	input wire word_t i_rs1,
	input wire word_t i_rs2,
	input wire i_wb_wr,
	input wire reg_index_t i_wb_rd,
	input wire word_t i_wb_data,
	output logic o_busy,
	output logic o_jump,
	output word_t o_jump_pc,
	output execute_data_t o_data
);

	execute_data_t payload;
	execute_data_t staged;
	logic valid_q;
	logic forward_ready;
	word_t operand_a;
	word_t store_value;
	word_t operand_b;
	word_t alu_result;
	logic taken;
	logic advance;

	// ========================================
	// Forwarding, nearest producer wins

	// Load address is not the load result
	assign forward_ready = valid_q && payload.writes_rd && !payload.is_load;

	always_comb begin
		operand_a = i_rs1;
		if (i_wb_wr && i_wb_rd == i_data.rs1) begin
			operand_a = i_wb_data;
		end
		if (forward_ready && payload.rd == i_data.rs1) begin
			operand_a = payload.result;
		end
		store_value = i_rs2;
		if (i_wb_wr && i_wb_rd == i_data.rs2) begin
			store_value = i_wb_data;
		end
		if (forward_ready && payload.rd == i_data.rs2) begin
			store_value = payload.result;
		end
	end

	// Load-use: wait until the load has reached the register file
	assign o_busy = i_data.valid && valid_q && payload.is_load && payload.writes_rd
		&& (payload.rd == i_data.rs1 || payload.rd == i_data.rs2);

	// ========================================
	// ALU and branch resolution

	assign operand_b = i_data.use_immediate ? i_data.immediate : store_value;

	always_comb begin
		case (i_data.alu_op)
			ALU_ADD: alu_result = operand_a + operand_b;
			ALU_SUB: alu_result = operand_a - operand_b;
			ALU_AND: alu_result = operand_a & operand_b;
			ALU_OR: alu_result = operand_a | operand_b;
			ALU_XOR: alu_result = operand_a ^ operand_b;
			default: alu_result = operand_b;
		endcase
	end

	assign taken = i_data.is_branch && ((operand_a == store_value) != i_data.branch_not_equal);
	assign advance = !i_memory_busy && !o_busy;
	assign o_jump = i_data.valid && advance && (i_data.is_jump || taken);
	assign o_jump_pc = i_data.pc + i_data.immediate;

	always_comb begin
		staged.valid = i_data.valid;
		staged.rd = i_data.rd;
		staged.writes_rd = i_data.writes_rd;
		staged.result = i_data.is_jump ? i_data.pc + 32'd4 : alu_result;
		staged.store_data = store_value;
		staged.is_load = i_data.is_load;
		staged.is_store = i_data.is_store;
	end

	// Bubble goes out while a load-use hold is on
	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			valid_q <= 1'b0;
		end else if (!i_memory_busy) begin
			valid_q <= i_data.valid && !o_busy;
		end
	end

	always_ff @(posedge i_clock) begin
		if (!i_memory_busy) begin
			payload <= staged;
		end
	end

	always_comb begin
		o_data = payload;
		o_data.valid = valid_q;
	end

	// The jump flushes decode, so the redirect lasts one cycle
	assert property (@(posedge i_clock) disable iff (!i_rst_n) o_jump |=> !o_jump);

endmodule

`default_nettype wire

// ==== rtl/cpu_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_fetch import cpu_pkg::*; #(
	parameter word_t RESET_VECTOR = 32'h00000000
)(
	input wire i_clock,
	input wire i_rst_n,

	input wire i_jump,
	input wire word_t i_jump_pc,
	input wire i_busy,

	// Instruction bus
	output logic o_bus_request,
	input wire i_bus_ready,
	output word_t o_bus_address,
	input wire word_t i_bus_rdata,

	output fetch_data_t o_data
);

	word_t pc;
	logic data_valid;
	word_t data_pc;
	word_t data_instruction;
	logic slot_free;
	logic accept;

	// Slot is free when decode takes it this cycle or it only holds a bubble
	assign slot_free = !i_busy || !data_valid;

	// A word arriving into a full slot is dropped and the same pc fetched again
	assign accept = o_bus_request && i_bus_ready && slot_free && !i_jump;

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			pc <= RESET_VECTOR;
			o_bus_request <= 1'b0;
			data_valid <= 1'b0;
		end else begin
			o_bus_request <= 1'b1;
			if (i_jump) begin
				pc <= i_jump_pc;
				data_valid <= 1'b0;
			end else if (accept) begin
				pc <= pc + 32'd4;
				data_valid <= 1'b1;
			end else if (!i_busy) begin
				data_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (accept) begin
			data_pc <= pc;
			data_instruction <= i_bus_rdata;
		end
	end

	assign o_bus_address = pc;
	assign o_data = '{valid: data_valid, pc: data_pc, instruction: data_instruction};

	// Waiting request keeps its address unless a jump abandons it
	assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_bus_request && !i_bus_ready && !i_jump |=> o_bus_request && $stable(o_bus_address));

endmodule

`default_nettype wire

// ==== rtl/cpu_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_memory import cpu_pkg::*; (
	input wire i_clock,
	input wire i_rst_n,
	input wire execute_data_t i_data,

	// Data bus
	output logic o_bus_request,
	output logic o_bus_rw,
	input wire i_bus_ready,
	output word_t o_bus_address,
	input wire word_t i_bus_rdata,
	output word_t o_bus_wdata,
	output logic [3:0] o_bus_wmask,
	output logic o_busy,

	// Register write port
	output logic o_wb_wr,
	output reg_index_t o_wb_rd,
	output word_t o_wb_data
);

	logic access;

	// ========================================
	// Bus access

	// Execute register is frozen while busy, so the request holds its fields
	assign access = i_data.valid && (i_data.is_load || i_data.is_store);

	assign o_bus_request = access;
	assign o_bus_rw = i_data.is_store;
	assign o_bus_address = i_data.result;
	assign o_bus_wdata = i_data.store_data;
	assign o_bus_wmask = {4{i_data.is_store}};
	assign o_busy = access && !i_bus_ready;

	// ========================================
	// Writeback

	// ALU results write at once, load data in the ready cycle
	assign o_wb_wr = i_data.valid && i_data.writes_rd && (!i_data.is_load || i_bus_ready);
	assign o_wb_rd = i_data.rd;
	assign o_wb_data = i_data.is_load ? i_bus_rdata : i_data.result;

	assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_bus_request && !i_bus_ready |=> o_bus_request && $stable(o_bus_address)
			&& $stable(o_bus_rw));

endmodule

`default_nettype wire

// ==== rtl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_index_t;

	// ========================================
	// Major opcodes of the supported subset

	localparam logic [6:0] OP_LUI = 7'b0110111;
	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] OP_REG = 7'b0110011;
	localparam logic [6:0] OP_LOAD = 7'b0000011;
	localparam logic [6:0] OP_STORE = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_JAL = 7'b1101111;

	// PASS_B hands the immediate straight through for LUI
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS_B
	} alu_op_t;

	// ========================================
	// Stage payloads

	typedef struct packed {
		logic valid;
		word_t pc;
		word_t instruction;
	} fetch_data_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		reg_index_t rs1;
		reg_index_t rs2;
		reg_index_t rd;
		word_t immediate;
		alu_op_t alu_op;
		logic use_immediate;
		logic is_load;
		logic is_store;
		logic is_branch;
		logic branch_not_equal;
		logic is_jump;
		logic writes_rd;
	} decode_data_t;

	// Result is the ALU value, the link address or the memory address
	typedef struct packed {
		logic valid;
		reg_index_t rd;
		logic writes_rd;
		word_t result;
		word_t store_data;
		logic is_load;
		logic is_store;
	} execute_data_t;

endpackage

`default_nettype wire

// ==== rtl/cpu_registers.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_registers import cpu_pkg::*; #(
	parameter word_t STACK_POINTER = 32'h00001000
)(
	input wire i_clock,
	input wire i_rst_n,
	input wire reg_index_t i_rs1,
	input wire reg_index_t i_rs2,
	input wire i_wr,
	input wire reg_index_t i_rd,
	input wire word_t i_wdata,
	output word_t o_rs1,
	output word_t o_rs2
);

	word_t registers [32];
	logic write;

	assign write = i_wr && (i_rd != '0);

	// x0 holds zero from reset on and is never written
	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			registers[0] <= '0;
			registers[2] <= STACK_POINTER;
		end else if (write) begin
			registers[i_rd] <= i_wdata;
		end
	end

	// Write-through so a same-cycle read sees the new value
	always_comb begin
		o_rs1 = registers[i_rs1];
		if (write && i_rd == i_rs1) begin
			o_rs1 = i_wdata;
		end
		o_rs2 = registers[i_rs2];
		if (write && i_rd == i_rs2) begin
			o_rs2 = i_wdata;
		end
	end

	assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_wr && i_rd == '0 |=> (i_rs1 != '0 || o_rs1 == '0) && (i_rs2 != '0 || o_rs2 == '0));

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_cpu \
	-Mdir obj_dir -o tb_cpu_sim

obj_dir/tb_cpu_sim > sim.log 2>&1
cat sim.log

if grep -qx "SIMULATION PASSED" sim.log; then
	exit 0
else
	exit 1
fi

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int HALF_PERIOD_NS = 5
)(
	output logic o_clock
);

	// 10 ns period with the defaults
	initial begin
		o_clock = 1'b0;
	end

	always #(HALF_PERIOD_NS) o_clock = ~o_clock;

endmodule

`default_nettype wire

// ==== testbench/tb_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

	localparam int ROWS = 5;
	localparam int MAX_PROGRAM = 16;
	localparam int MAX_STORES = 8;
	localparam word_t STACK_POINTER = 32'h00001000;

	wire clock;
	logic rst_n;
	logic ibus_ready;
	word_t ibus_rdata;
	logic dbus_ready;
	word_t dbus_rdata;
	wire o_ibus_request;
	wire word_t o_ibus_address;
	wire o_dbus_request;
	wire o_dbus_rw;
	wire word_t o_dbus_address;
	wire word_t o_dbus_wdata;
	wire [3:0] o_dbus_wmask;
	wire o_fault;

	// Program table and expected stores
	word_t program_table [ROWS][MAX_PROGRAM];
	int program_length [ROWS];
	word_t exp_store_addr [ROWS][MAX_STORES];
	word_t exp_store_data [ROWS][MAX_STORES];
	int store_count [ROWS];
	logic fault_expected [ROWS];

	// Bus models
	word_t imem [64];
	word_t dmem [word_t];
	word_t seen_addr [$];
	word_t seen_data [$];
	word_t seed = 32'hbd1c;
	logic ibus_pending;
	logic [1:0] ibus_wait;
	logic dbus_pending;
	logic [1:0] dbus_wait;
	word_t halt_pc;
	logic seen_after;
	logic halted;

	int checks_run;
	int value_errors;
	int other_errors;

	tb_clock u_clock (
		.o_clock(clock)
	);

	cpu #(
		.RESET_VECTOR(32'h00000000),
		.STACK_POINTER(STACK_POINTER)
	) u_dut (
		.i_clock(clock),
		.i_rst_n(rst_n),
		.o_ibus_request(o_ibus_request),
		.i_ibus_ready(ibus_ready),
		.o_ibus_address(o_ibus_address),
		.i_ibus_rdata(ibus_rdata),
		.o_dbus_request(o_dbus_request),
		.o_dbus_rw(o_dbus_rw),
		.i_dbus_ready(dbus_ready),
		.o_dbus_address(o_dbus_address),
		.i_dbus_rdata(dbus_rdata),
		.o_dbus_wdata(o_dbus_wdata),
		.o_dbus_wmask(o_dbus_wmask),
		.o_fault(o_fault)
	);

	// ========================================
	// Instruction encoders

	function automatic word_t encode_i(logic [6:0] opcode, logic [2:0] funct3, reg_index_t rd,
		reg_index_t rs1, logic [11:0] imm);
		return {imm, rs1, funct3, rd, opcode};
	endfunction

	function automatic word_t encode_r(logic [6:0] funct7, logic [2:0] funct3, reg_index_t rd,
		reg_index_t rs1, reg_index_t rs2);
		return {funct7, rs2, rs1, funct3, rd, OP_REG};
	endfunction

	function automatic word_t encode_s(reg_index_t rs2, reg_index_t rs1, logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
	endfunction

	function automatic word_t encode_b(logic [2:0] funct3, reg_index_t rs1, reg_index_t rs2,
		logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], OP_BRANCH};
	endfunction

	function automatic word_t encode_j(reg_index_t rd, logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
	endfunction

	function automatic word_t encode_u(reg_index_t rd, logic [19:0] upper);
		return {upper, rd, OP_LUI};
	endfunction

	function automatic word_t lcg_next(word_t state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [1:0] draw_wait();
		seed = lcg_next(seed);
		return seed[17:16];
	endfunction

	// Unwritten data memory reads back its own address folded with a constant
	function automatic word_t data_fill(word_t address);
		return address ^ 32'hc0de0000;
	endfunction

	task automatic add_instr(input int row, input word_t instr);
		program_table[row][program_length[row]] = instr;
		program_length[row]++;
	endtask

	task automatic add_store(input int row, input word_t address, input word_t data);
		exp_store_addr[row][store_count[row]] = address;
		exp_store_data[row][store_count[row]] = data;
		store_count[row]++;
	endtask

	// ========================================
	// Program table

	task automatic build_table();
		for (int r = 0; r < ROWS; r++) begin
			program_length[r] = 0;
			store_count[r] = 0;
			fault_expected[r] = 1'b0;
		end
		// Immediate ALU ops and LUI
		add_instr(0, encode_i(OP_IMM, 3'b000, 5'd1, 5'd0, 12'h123));
		add_instr(0, encode_i(OP_IMM, 3'b111, 5'd3, 5'd1, 12'h0f0));
		add_instr(0, encode_i(OP_IMM, 3'b110, 5'd4, 5'd1, 12'h700));
		add_instr(0, encode_i(OP_IMM, 3'b100, 5'd5, 5'd1, 12'hfff));
		add_instr(0, encode_u(5'd6, 20'habcde));
		add_instr(0, encode_s(5'd3, 5'd0, 12'h100));
		add_instr(0, encode_s(5'd4, 5'd0, 12'h104));
		add_instr(0, encode_s(5'd5, 5'd0, 12'h108));
		add_instr(0, encode_s(5'd6, 5'd0, 12'h10c));
		add_instr(0, encode_s(5'd1, 5'd0, 12'h110));
		add_instr(0, encode_j(5'd0, 21'd0));
		add_store(0, 32'h100, 32'h00000020);
		add_store(0, 32'h104, 32'h00000723);
		add_store(0, 32'h108, 32'hfffffedc);
		add_store(0, 32'h10c, 32'habcde000);
		add_store(0, 32'h110, 32'h00000123);
		// Register ALU ops on 100 and -7
		add_instr(1, encode_i(OP_IMM, 3'b000, 5'd1, 5'd0, 12'd100));
		add_instr(1, encode_i(OP_IMM, 3'b000, 5'd3, 5'd0, 12'hff9));
		add_instr(1, encode_r(7'b0000000, 3'b000, 5'd4, 5'd1, 5'd3));
		add_instr(1, encode_r(7'b0100000, 3'b000, 5'd5, 5'd1, 5'd3));
		add_instr(1, encode_r(7'b0000000, 3'b111, 5'd6, 5'd1, 5'd3));
		add_instr(1, encode_r(7'b0000000, 3'b110, 5'd7, 5'd1, 5'd3));
		add_instr(1, encode_r(7'b0000000, 3'b100, 5'd8, 5'd1, 5'd3));
		for (int k = 0; k < 5; k++) begin
			add_instr(1, encode_s(reg_index_t'(k + 4), 5'd0, 12'(32'h200 + 4 * k)));
		end
		add_instr(1, encode_j(5'd0, 21'd0));
		add_store(1, 32'h200, 32'h0000005d);
		add_store(1, 32'h204, 32'h0000006b);
		add_store(1, 32'h208, 32'h00000060);
		add_store(1, 32'h20c, 32'hfffffffd);
		add_store(1, 32'h210, 32'hffffff9d);
		// Forwarding chain, load-use and the stack pointer
		add_instr(2, encode_i(OP_IMM, 3'b000, 5'd1, 5'd0, 12'd5));
		add_instr(2, encode_i(OP_IMM, 3'b000, 5'd1, 5'd1, 12'd3));
		add_instr(2, encode_r(7'b0000000, 3'b000, 5'd3, 5'd1, 5'd1));
		add_instr(2, encode_s(5'd3, 5'd2, 12'hffc));
		add_instr(2, encode_i(OP_LOAD, 3'b010, 5'd4, 5'd2, 12'hffc));
		add_instr(2, encode_i(OP_IMM, 3'b000, 5'd5, 5'd4, 12'd1));
		add_instr(2, encode_s(5'd5, 5'd2, 12'hff8));
		add_instr(2, encode_s(5'd2, 5'd0, 12'h300));
		add_instr(2, encode_i(OP_LOAD, 3'b010, 5'd6, 5'd0, 12'h040));
		add_instr(2, encode_s(5'd6, 5'd0, 12'h304));
		add_instr(2, encode_j(5'd0, 21'd0));
		add_store(2, STACK_POINTER - 32'd4, 32'h00000010);
		add_store(2, STACK_POINTER - 32'd8, 32'h00000011);
		add_store(2, 32'h300, STACK_POINTER);
		add_store(2, 32'h304, 32'hc0de0040);
		// Branches and JAL, skipped stores go to 0x400, 0x404, 0x40c and 0x410
		add_instr(3, encode_i(OP_IMM, 3'b000, 5'd1, 5'd0, 12'd7));
		add_instr(3, encode_i(OP_IMM, 3'b000, 5'd3, 5'd0, 12'd7));
		add_instr(3, encode_b(3'b000, 5'd1, 5'd3, 13'd12));
		add_instr(3, encode_s(5'd1, 5'd0, 12'h400));
		add_instr(3, encode_s(5'd1, 5'd0, 12'h404));
		add_instr(3, encode_b(3'b001, 5'd1, 5'd3, 13'd8));
		add_instr(3, encode_s(5'd3, 5'd0, 12'h408));
		add_instr(3, encode_b(3'b001, 5'd1, 5'd0, 13'd8));
		add_instr(3, encode_s(5'd1, 5'd0, 12'h40c));
		add_instr(3, encode_j(5'd5, 21'd8));
		add_instr(3, encode_s(5'd1, 5'd0, 12'h410));
		add_instr(3, encode_s(5'd5, 5'd0, 12'h414));
		add_instr(3, encode_b(3'b000, 5'd1, 5'd0, 13'd8));
		add_instr(3, encode_s(5'd1, 5'd0, 12'h418));
		add_instr(3, encode_j(5'd0, 21'd0));
		add_store(3, 32'h408, 32'h00000007);
		add_store(3, 32'h414, 32'h00000028);
		add_store(3, 32'h418, 32'h00000007);
		// M-extension encoding is illegal here
		add_instr(4, encode_i(OP_IMM, 3'b000, 5'd1, 5'd0, 12'h055));
		add_instr(4, encode_r(7'b0000001, 3'b000, 5'd3, 5'd1, 5'd1));
		add_instr(4, encode_s(5'd1, 5'd0, 12'h500));
		add_instr(4, encode_j(5'd0, 21'd0));
		add_store(4, 32'h500, 32'h00000055);
		fault_expected[4] = 1'b1;
	endtask

	// ========================================
	// Compare tasks

	task automatic check_word(input string name, input word_t actual, input word_t expected);
		checks_run++;
		if (actual !== expected) begin
			$display("FAILED %s: got %h, expected %h", name, actual, expected);
			value_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic [3:0] actual,
		input logic [3:0] expected);
		checks_run++;
		if (actual !== expected) begin
			$display("FAILED %s: got %h, expected %h", name, actual, expected);
			value_errors++;
		end
	endtask

	// ========================================
	// Bus models with random wait states

	task automatic step_ibus();
		if (o_ibus_request) begin
			if (o_ibus_address == halt_pc + 32'd4) begin
				seen_after = 1'b1;
			end else if (seen_after && o_ibus_address == halt_pc) begin
				halted = 1'b1;
			end
			if (!ibus_pending) begin
				ibus_pending = 1'b1;
				ibus_wait = draw_wait();
			end
			if (ibus_wait == 2'd0) begin
				ibus_ready = 1'b1;
				ibus_rdata = imem[o_ibus_address[7:2]];
				ibus_pending = 1'b0;
			end else begin
				ibus_ready = 1'b0;
				ibus_wait = ibus_wait - 2'd1;
			end
		end else begin
			ibus_ready = 1'b0;
			ibus_pending = 1'b0;
		end
	endtask

	task automatic step_dbus();
		if (o_dbus_request) begin
			if (!dbus_pending) begin
				dbus_pending = 1'b1;
				dbus_wait = draw_wait();
			end
			if (dbus_wait == 2'd0) begin
				dbus_ready = 1'b1;
				dbus_pending = 1'b0;
				if (o_dbus_rw) begin
					check_flag("o_dbus_wmask", o_dbus_wmask, 4'hf);
					dmem[o_dbus_address] = o_dbus_wdata;
					seen_addr.push_back(o_dbus_address);
					seen_data.push_back(o_dbus_wdata);
				end else if (dmem.exists(o_dbus_address)) begin
					dbus_rdata = dmem[o_dbus_address];
				end else begin
					dbus_rdata = data_fill(o_dbus_address);
				end
			end else begin
				dbus_ready = 1'b0;
				dbus_wait = dbus_wait - 2'd1;
			end
		end else begin
			dbus_ready = 1'b0;
			dbus_pending = 1'b0;
		end
	endtask

	always @(posedge clock) begin
		#1;
		step_ibus();
		step_dbus();
	end

	// ========================================
	// Program runs

	// Unused words are NOPs whose immediate is the word index
	task automatic load_program(input int row);
		for (int i = 0; i < 64; i++) begin
			if (i < program_length[row]) begin
				imem[i] = program_table[row][i];
			end else begin
				imem[i] = encode_i(OP_IMM, 3'b000, 5'd0, 5'd0, i[11:0]);
			end
		end
		dmem.delete();
		halt_pc = word_t'((program_length[row] - 1) * 4);
	endtask

	task automatic apply_reset();
		@(posedge clock);
		#1;
		rst_n = 1'b0;
		repeat (3) @(posedge clock);
		#1;
		rst_n = 1'b1;
		check_flag("o_fault", {3'b000, o_fault}, 4'h0);
		check_flag("o_dbus_request", {3'b000, o_dbus_request}, 4'h0);
		check_flag("o_ibus_request", {3'b000, o_ibus_request}, 4'h0);
		seen_addr.delete();
		seen_data.delete();
		seen_after = 1'b0;
		halted = 1'b0;
	endtask

	task automatic run_program(input int row);
		int total;
		load_program(row);
		apply_reset();
		while (!halted) begin
			@(posedge clock);
		end
		#1;
		check_flag("o_fault", {3'b000, o_fault}, {3'b000, fault_expected[row]});
		total = (seen_addr.size() > store_count[row]) ? seen_addr.size() : store_count[row];
		for (int i = 0; i < total; i++) begin
			if (i >= seen_addr.size()) begin
				$display("Program %0d: store %0d to address %h never happened", row, i,
					exp_store_addr[row][i]);
				other_errors++;
			end else if (i >= store_count[row]) begin
				$display("Program %0d: unexpected extra store of %h to address %h", row,
					seen_data[i], seen_addr[i]);
				other_errors++;
			end else begin
				check_word("o_dbus_address", seen_addr[i], exp_store_addr[row][i]);
				check_word("o_dbus_wdata", seen_data[i], exp_store_data[row][i]);
			end
		end
		$display("Program %0d finished with %0d stores", row, seen_addr.size());
	endtask

	initial begin
		rst_n = 1'b0;
		ibus_ready = 1'b0;
		ibus_rdata = '0;
		dbus_ready = 1'b0;
		dbus_rdata = '0;
		ibus_pending = 1'b0;
		ibus_wait = 2'd0;
		dbus_pending = 1'b0;
		dbus_wait = 2'd0;
		halt_pc = '0;
		seen_after = 1'b0;
		halted = 1'b0;
		checks_run = 0;
		value_errors = 0;
		other_errors = 0;
		build_table();
		for (int row = 0; row < ROWS; row++) begin
			run_program(row);
		end
		// Sticky fault must clear on the next reset
		apply_reset();
		$display("Checks: %0d, value errors: %0d, other errors: %0d", checks_run,
			value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (ROWS * 2000) @(posedge clock);
		$display("Timeout: a program did not reach its final jump in time");
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire
